// File: build.f
+incdir+design
design/sound_pkg.sv
design/pulse_filter.sv
design/channel_mixer.sv
design/sample_combiner.sv
design/codec_link.sv
design/sound_codec.sv
tests/sound_codec_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -euo pipefail

cd "$(dirname "$0")"

# Build the testbench with the RTL from the file list
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f build.f --top-module sound_codec_tb -o sound_codec_sim

# Run and keep the log
./obj_dir/sound_codec_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "Result: FAIL"
	exit 1
fi

if ! grep -q "Simulation passed" sim.log; then
	echo "Result: no pass line in log"
	exit 1
fi

echo "Result: PASS"

// File: tests/sound_codec_tb.sv
`timescale 1ns/1ps
`include "sound_config.svh"

module sound_codec_tb import sound_pkg::*; ();

	// Clocks per codec frame and frames per filter step
	localparam int FRAME_CYC    = 64 * `SC_BCK_HALF;
	localparam int DECIM_FRAMES = (1 << `SC_DECIM_BITS) / FRAME_CYC;
	localparam int RAND_SETS    = 4;

	// Frame budget of all tests, for the watchdog
	localparam int FRAMES_TOTAL = 6 + RAND_SETS * 6 + (6 * DECIM_FRAMES + 11) + 12;
	localparam int WATCH_NS     = (FRAMES_TOTAL + 20) * FRAME_CYC * 40;

	logic        clk12 = 1'b0;
	logic        rst_n;
	logic [3:0]  pulses;
	psg_in_t     psg;
	logic        aud_adcdat = 1'b0;
	logic        aud_xck;
	logic        aud_bck;
	logic        aud_lrck;
	logic        aud_adclrck;
	logic        aud_data;
	logic        tapein;

	// Frame capture and ADC drive state
	logic        bck_q;
	logic        lrck_q;
	logic [15:0] shift_in;
	logic [15:0] left_hold;
	logic [15:0] cap_left;
	logic [15:0] cap_right;
	logic        frame_done = 1'b0;
	logic [4:0]  adc_slot;
	logic [15:0] adc_word;
	logic [15:0] tape_word = 16'h0000;

	// Master clock edge counts
	int          clk_edges = 0;
	int          xck_edges = 0;

	// Expectations and check enables
	logic        idle_chk = 1'b0;
	logic        word_chk = 1'b0;
	logic        tape_chk = 1'b0;
	logic [15:0] exp_left = 16'h8000;
	logic [15:0] exp_right = 16'h8000;
	logic        tape_exp = 1'b0;
	int          errors = 0;
	int          n_pass = 0;
	int          n_fail = 0;
	int          err_start;
	integer      seed;
	logic [63:0] rnd;

	always #20 clk12 = ~clk12;

	sound_codec dut (
		.clk12      (clk12),
		.rst_n      (rst_n),
		.pulses     (pulses),
		.psg        (psg),
		.aud_adcdat (aud_adcdat),
		.aud_xck    (aud_xck),
		.aud_bck    (aud_bck),
		.aud_lrck   (aud_lrck),
		.aud_adclrck(aud_adclrck),
		.aud_data   (aud_data),
		.tapein     (tapein)
	);

	// --------------------
	// Reference model
	// --------------------

	// Left side, c channels panned left
	function automatic logic [15:0] left_level(input psg_in_t p);
		return {8'h00, p.covox} * 16'd16 + {8'h00, p.ay_c} * 16'd16
			+ {8'h00, p.ay_b} * 16'd8 + {8'h00, p.rs_c} * 16'd16
			+ {8'h00, p.rs_b} * 16'd8;
	endfunction

	// Right side, a channels instead
	function automatic logic [15:0] right_level(input psg_in_t p);
		return {8'h00, p.covox} * 16'd16 + {8'h00, p.ay_a} * 16'd16
			+ {8'h00, p.ay_b} * 16'd8 + {8'h00, p.rs_a} * 16'd16
			+ {8'h00, p.rs_b} * 16'd8;
	endfunction

	// Settled filter output for static pulse lines
	function automatic logic [15:0] pulse_level(input logic [3:0] p);
		logic [15:0] avg;
		avg = 16'd64 * (16'(p[0]) + 16'(p[1]) + 16'(p[2]));
		return (avg >> 1) * 16'd128 + 16'(p[3]) * 16'd4096;
	endfunction

	// --------------------
	// Frame model
	// --------------------

	// All pins read on the falling clock, stable there
	always @(negedge clk12) begin
		frame_done = 1'b0;
		if (!rst_n) begin
			bck_q    = 1'b0;
			lrck_q   = 1'b0;
			shift_in = '0;
			adc_slot = 5'd31;
			adc_word = '0;
		end else begin
			// Bit sampled on bck rise
			if (aud_bck && !bck_q)
				shift_in = {shift_in[14:0], aud_data};
			// Word select edges close each half
			if (aud_lrck && !lrck_q)
				left_hold = shift_in;
			if (!aud_lrck && lrck_q) begin
				cap_left   = left_hold;
				cap_right  = shift_in;
				frame_done = 1'b1;
			end
			// Next ADC bit after bck fall, word swapped only at slot 0
			if (!aud_bck && bck_q) begin
				if (!aud_lrck && lrck_q)
					adc_slot = 5'd0;
				else
					adc_slot = adc_slot + 5'd1;
				if (adc_slot == 5'd0)
					adc_word = tape_word;
				aud_adcdat = adc_slot[4] ? 1'b0 : adc_word[4'd15 - adc_slot[3:0]];
			end
			bck_q  = aud_bck;
			lrck_q = aud_lrck;
		end
	end

	// Rising edges of the system clock and of the codec master clock
	always @(posedge clk12)
		clk_edges <= clk_edges + 1;

	always @(posedge aud_xck)
		xck_edges <= xck_edges + 1;

	// --------------------
	// Checks
	// --------------------

	a_idle: assert property (@(posedge clk12) idle_chk |-> !aud_bck && !aud_lrck
		&& !aud_data && !tapein && aud_adclrck == aud_lrck)
		else begin
			$display("Reset state wrong at %0t: codec pins or tapein not idle", $time);
			errors++;
		end

	// Master clock follows clk12 edge for edge
	a_xck: assert property (@(negedge clk12) xck_edges == clk_edges)
		else begin
			$display("Mismatch at %0t: aud_xck rising edges expected %0d got %0d",
				$time, $sampled(clk_edges), $sampled(xck_edges));
			errors++;
		end

	a_left_word: assert property (@(posedge clk12) frame_done && word_chk |->
		cap_left == exp_left)
		else begin
			$display("Mismatch at %0t: left word expected %h got %h",
				$time, exp_left, cap_left);
			errors++;
		end

	a_right_word: assert property (@(posedge clk12) frame_done && word_chk |->
		cap_right == exp_right)
		else begin
			$display("Mismatch at %0t: right word expected %h got %h",
				$time, exp_right, cap_right);
			errors++;
		end

	a_tape: assert property (@(posedge clk12) tape_chk |-> tapein == tape_exp)
		else begin
			$display("Mismatch at %0t: tapein expected %0b got %0b",
				$time, tape_exp, $sampled(tapein));
			errors++;
		end

	// --------------------
	// Test helpers
	// --------------------

	task automatic wait_frames(input int n);
		repeat (n) @(posedge frame_done);
	endtask

	task automatic report_test(input string name);
		if (errors == err_start) begin
			n_pass++;
			$display("%s: pass", name);
		end else begin
			n_fail++;
			$display("%s: FAIL with %0d errors", name, errors - err_start);
		end
		err_start = errors;
	endtask

	// Settle, then check a few frames against fixed words
	task automatic check_words(input logic [15:0] l, input logic [15:0] r, input int settle);
		wait_frames(settle);
		exp_left  = l ^ 16'h8000;
		exp_right = r ^ 16'h8000;
		word_chk  = 1'b1;
		wait_frames(3);
		word_chk  = 1'b0;
	endtask

	// ADC word with a given offset top byte
	task automatic tape_step(input logic [7:0] lvl, input logic want, input logic hold);
		tape_chk  = hold;
		tape_word = {lvl ^ 8'h80, 8'h00};
		wait_frames(2);
		tape_exp  = want;
		tape_chk  = 1'b1;
		wait_frames(1);
	endtask

	// --------------------
	// Stimulus
	// --------------------

	initial begin
		seed      = 31376;
		err_start = 0;
		rst_n     = 1'b0;
		pulses    = '0;
		psg       = '0;

		// Reset idle state, up to the first bck rise
		@(negedge clk12);
		idle_chk = 1'b1;
		repeat (4) @(negedge clk12);
		rst_n = 1'b1;
		@(negedge clk12);
		idle_chk = 1'b0;
		report_test("reset_idle");

		// Silence reads as 0x8000
		check_words(16'h0000, 16'h0000, 3);
		report_test("all_zero");

		// Static random chip levels
		repeat (RAND_SETS) begin
			rnd = {$random(seed), $random(seed)};
			psg = rnd[55:0];
			check_words(left_level(psg), right_level(psg), 3);
		end
		report_test("psg_weights");

		// Timer pulse through the moving average, then the beeper
		psg    = '0;
		pulses = 4'b0001;
		check_words(pulse_level(pulses), pulse_level(pulses), 6 * DECIM_FRAMES);
		pulses = 4'b1001;
		check_words(pulse_level(pulses), pulse_level(pulses), 3);
		pulses = 4'b0000;
		report_test("pulse_filter");

		// Tape slicer hysteresis
		tape_step(8'd140, 1'b1, 1'b0);
		tape_step(8'd126, 1'b1, 1'b1);
		tape_step(8'd110, 1'b0, 1'b0);
		tape_step(8'd130, 1'b0, 1'b1);
		tape_chk = 1'b0;
		report_test("tape_slicer");

		$display("Tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
		if (n_fail == 0 && errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCH_NS);
		$display("Timeout at %0t: the tests did not finish in time", $time);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: design/sound_codec.sv
`timescale 1ns/1ps

module sound_codec import sound_pkg::*; (
	input  logic       clk12,
	input  logic       rst_n,
	input  logic [3:0] pulses,
	input  psg_in_t    psg,
	input  logic       aud_adcdat,
	output logic       aud_xck,
	output logic       aud_bck,
	output logic       aud_lrck,
	output logic       aud_adclrck,
	output logic       aud_data,
	output logic       tapein
);

	pulse_mix_t pulse_mix;
	stereo_t    psg_mix;
	stereo_t    sample;
	logic       req;
	logic       ack;

	// Codec master clock straight from the system clock
	assign aud_xck = clk12;

	// ADC shares the DAC word select
	assign aud_adclrck = aud_lrck;

	// --------------------
	// Mixing path
	// --------------------

	pulse_filter u_pulse_filter (
		.clk12 (clk12),
		.rst_n (rst_n),
		.pulses(pulses),
		.mix   (pulse_mix)
	);

	channel_mixer u_channel_mixer (
		.clk12(clk12),
		.rst_n(rst_n),
		.psg  (psg),
		.mix  (psg_mix)
	);

	sample_combiner u_sample_combiner (
		.clk12  (clk12),
		.rst_n  (rst_n),
		.pulse  (pulse_mix),
		.psg_mix(psg_mix),
		.sample (sample),
		.req    (req),
		.ack    (ack)
	);

	// --------------------
	// Codec pins
	// --------------------

	codec_link u_codec_link (
		.clk12 (clk12),
		.rst_n (rst_n),
		.sample(sample),
		.req   (req),
		.ack   (ack),
		.bck   (aud_bck),
		.lrck  (aud_lrck),
		.data  (aud_data),
		.adcdat(aud_adcdat),
		.tapein(tapein)
	);

endmodule

// File: design/codec_link.sv
`timescale 1ns/1ps
`include "sound_config.svh"

module codec_link import sound_pkg::*; (
	input  logic    clk12,
	input  logic    rst_n,
	input  stereo_t sample,
	input  logic    req,
	output logic    ack,
	output logic    bck,
	output logic    lrck,
	output logic    data,
	input  logic    adcdat,
	output logic    tapein
);

	localparam int SW    = `SC_SAMPLE_W;
	localparam int DIV_W = $clog2(`SC_BCK_HALF);

	// Slicer thresholds around midpoint
	localparam logic [7:0] LVL_LO = 8'(128 - `SC_HYST);
	localparam logic [7:0] LVL_HI = 8'(128 + `SC_HYST);

	logic [DIV_W-1:0] div;
	logic             tick;
	logic             bck_rise;
	logic             bck_fall;
	logic [4:0]       slot;
	logic [4:0]       slot_nxt;
	logic             frame_start;
	logic [2*SW-1:0]  shreg;
	stereo_t          last;
	logic [SW-1:0]    adc_sh;
	logic [SW-1:0]    linein;
	logic [7:0]       level;

	// --------------------
	// Frame timing
	// --------------------

	assign tick     = (div == DIV_W'(`SC_BCK_HALF - 1));
	assign bck_rise = tick && !bck;
	assign bck_fall = tick && bck;
	assign slot_nxt = slot + 5'd1;

	// Slot wraps to 0 together with lrck falling
	assign frame_start = bck_fall && (slot_nxt == 5'd0);

	always_ff @(posedge clk12) begin
		if (!rst_n) begin
			div  <= '0;
			bck  <= 1'b0;
			slot <= 5'd31; // first fall opens slot 0
			lrck <= 1'b0;
		end else begin
			if (tick) begin
				div <= '0;
				bck <= ~bck;
			end else begin
				div <= div + 1'b1;
			end
			// Left half while lrck low
			if (bck_fall) begin
				slot <= slot_nxt;
				lrck <= slot_nxt[4];
			end
		end
	end

	// --------------------
	// DAC side
	// --------------------

	// MSB first, new bit on each bck fall
	always_ff @(posedge clk12) begin
		if (!rst_n) begin
			shreg <= '0;
			last  <= '0;
			ack   <= 1'b0;
		end else begin
			if (frame_start) begin
				if (req && !ack) begin
					shreg <= sample;
					last  <= sample;
					ack   <= 1'b1;
				end else begin
					// Nothing new, repeat previous word
					shreg <= last;
				end
			end else if (bck_fall) begin
				shreg <= {shreg[2*SW-2:0], 1'b0};
			end
			if (ack && !req)
				ack <= 1'b0;
		end
	end

	assign data = shreg[2*SW-1];

	// --------------------
	// ADC side and tape
	// --------------------

	// Only left slot kept, sampled on bck rise
	always_ff @(posedge clk12) begin
		if (bck_rise && !lrck)
			adc_sh <= {adc_sh[SW-2:0], adcdat};
	end

	// Word complete at the last left bit
	always_ff @(posedge clk12) begin
		if (!rst_n)
			linein <= '0;
		else if (bck_rise && !lrck && slot == 5'(SW - 1))
			linein <= {adc_sh[SW-2:0], adcdat};
	end

	// Offset top byte, 128 is line silence
	assign level = {~linein[SW-1], linein[SW-2:SW-8]};

	always_ff @(posedge clk12) begin
		if (!rst_n)
			tapein <= 1'b0;
		else if (level < LVL_LO)
			tapein <= 1'b0;
		else if (level > LVL_HI)
			tapein <= 1'b1;
	end

	// --------------------
	// Checks
	// --------------------

	// Answer only a pending request
	a_ack_rise: assert property (@(posedge clk12) disable iff (!rst_n)
		$rose(ack) |-> req);

	// Word select moves with bck fall at slot 0 or 16
	a_lrck_edge: assert property (@(posedge clk12) disable iff (!rst_n)
		$changed(lrck) |-> $fell(bck) && slot[3:0] == 4'd0);

endmodule

// File: design/sample_combiner.sv
`timescale 1ns/1ps
`include "sound_config.svh"

module sample_combiner import sound_pkg::*; (
	input  logic       clk12,
	input  logic       rst_n,
	input  pulse_mix_t pulse,
	input  stereo_t    psg_mix,
	output stereo_t    sample,
	output logic       req,
	input  logic       ack
);

	localparam int SW = `SC_SAMPLE_W;

	logic [SW-1:0] pulse_w;
	logic [SW-1:0] sum_l;
	logic [SW-1:0] sum_r;
	logic          capture;

	// --------------------
	// Pulse contribution
	// --------------------

	// Average halved then x128, beeper at 4096
	assign pulse_w = SW'({pulse.avg[7:1], 7'b0000000})
		+ SW'({pulse.direct, 12'h000});

	// Signed sums, one register stage
	always_ff @(posedge clk12) begin
		if (!rst_n) begin
			sum_l <= '0;
			sum_r <= '0;
		end else begin
			sum_l <= pulse_w + psg_mix.left;
			sum_r <= pulse_w + psg_mix.right;
		end
	end

	// --------------------
	// Handshake source
	// --------------------

	// Idle phase of the four-phase cycle
	assign capture = !req && !ack;

	always_ff @(posedge clk12) begin
		if (!rst_n) begin
			req <= 1'b0;
		end else if (capture) begin
			req <= 1'b1;
		end else if (req && ack) begin
			// Link has latched, release
			req <= 1'b0;
		end
	end

	// Sign flip gives codec offset form, 0x8000 is silence
	always_ff @(posedge clk12) begin
		if (capture) begin
			sample.left  <= {~sum_l[SW-1], sum_l[SW-2:0]};
			sample.right <= {~sum_r[SW-1], sum_r[SW-2:0]};
		end
	end

	// --------------------
	// Checks
	// --------------------

	// No withdrawal before the link answers
	a_req_hold: assert property (@(posedge clk12) disable iff (!rst_n)
		req && !ack |=> req);

	// Link may latch at any cycle while req is up
	a_sample_stable: assert property (@(posedge clk12) disable iff (!rst_n)
		req |=> $stable(sample));

endmodule

// File: design/channel_mixer.sv
`timescale 1ns/1ps

module channel_mixer import sound_pkg::*; (
	input  logic    clk12,
	input  logic    rst_n,
	input  psg_in_t psg,
	output stereo_t mix
);

	logic [15:0] covox_w;
	logic [15:0] center_w;
	logic [15:0] left_w;
	logic [15:0] right_w;

	// --------------------
	// Channel weights
	// --------------------

	// Covox at x16, goes to both sides
	assign covox_w = {4'b0000, psg.covox, 4'b0000};

	// B channels at x8 on both sides, centered image
	assign center_w = {5'b00000, psg.ay_b, 3'b000}
		+ {5'b00000, psg.rs_b, 3'b000};

	// C channels panned left at x16
	assign left_w = {4'b0000, psg.ay_c, 4'b0000}
		+ {4'b0000, psg.rs_c, 4'b0000};

	// A channels panned right at x16
	assign right_w = {4'b0000, psg.ay_a, 4'b0000}
		+ {4'b0000, psg.rs_a, 4'b0000};

	// --------------------
	// Output stage
	// --------------------

	// Peak is 16320, no wrap in 16 bits
	always_ff @(posedge clk12) begin
		if (!rst_n) begin
			mix <= '0;
		end else begin
			mix.left  <= covox_w + center_w + left_w;
			mix.right <= covox_w + center_w + right_w;
		end
	end

endmodule

// File: design/pulse_filter.sv
`timescale 1ns/1ps
`include "sound_config.svh"

module pulse_filter import sound_pkg::*; (
	input  logic       clk12,
	input  logic       rst_n,
	input  logic [3:0] pulses,
	output pulse_mix_t mix
);

	logic [`SC_DECIM_BITS-1:0] decim;
	logic                      strobe;
	logic                      strobe_q;
	logic [7:0]                hist [0:3];
	logic [7:0]                entry;

	// --------------------
	// Decimation strobe
	// --------------------

	// One strobe per counter wrap
	assign strobe = (decim == '0);

	// Three timer lines, each counted as 16
	assign entry = {3'b000, pulses[0], 4'b0000}
		+ {3'b000, pulses[1], 4'b0000}
		+ {3'b000, pulses[2], 4'b0000};

	always_ff @(posedge clk12) begin
		if (!rst_n) begin
			decim    <= '0;
			strobe_q <= 1'b0;
		end else begin
			decim    <= decim + 1'b1;
			strobe_q <= strobe;
		end
	end

	// --------------------
	// Moving average
	// --------------------

	always_ff @(posedge clk12) begin
		if (!rst_n) begin
			hist[0]    <= '0;
			hist[1]    <= '0;
			hist[2]    <= '0;
			hist[3]    <= '0;
			mix.avg    <= '0;
			mix.direct <= 1'b0;
		end else begin
			// History steps on the strobe
			if (strobe) begin
				hist[3] <= hist[2];
				hist[2] <= hist[1];
				hist[1] <= hist[0];
				hist[0] <= entry;
			end
			// Sum of the freshly shifted taps, one clock after strobe
			// Max 4 x 48 = 192, fits 8 bits
			if (strobe_q)
				mix.avg <= hist[0] + hist[1] + hist[2] + hist[3];
			// Beeper skips the filter
			mix.direct <= pulses[3];
		end
	end

endmodule

// File: design/sound_pkg.sv
`include "sound_config.svh"

package sound_pkg;

	// --------------------
	// Sound source inputs
	// --------------------

	// Raw 8-bit levels from both chips and the covox port
	typedef struct packed {
		logic [7:0] ay_a;
		logic [7:0] ay_b;
		logic [7:0] ay_c;
		logic [7:0] rs_a;
		logic [7:0] rs_b;
		logic [7:0] rs_c;
		logic [7:0] covox;
	} psg_in_t;

	// --------------------
	// Mixed audio words
	// --------------------

	// Left in the upper half, so it goes out first
	typedef struct packed {
		logic [`SC_SAMPLE_W-1:0] left;
		logic [`SC_SAMPLE_W-1:0] right;
	} stereo_t;

	// Filtered timer pulses
	typedef struct packed {
		logic [7:0] avg;    // four-tap sum
		logic       direct; // beeper, unfiltered
	} pulse_mix_t;

endpackage

// File: design/sound_config.svh
`ifndef SOUND_CONFIG_SVH
`define SOUND_CONFIG_SVH

// --------------------
// Pulse filter rate
// --------------------

// Decimation counter width, filter steps once per 256 clocks
`define SC_DECIM_BITS 8

// --------------------
// Codec frame timing
// --------------------

// clk12 cycles per half bit clock, 4 clocks per bit
`define SC_BCK_HALF 2

// Bits per codec sample, one channel
`define SC_SAMPLE_W 16

// Tape slicer half window around midpoint 128
`define SC_HYST 4

`endif
